// ==== mbu_addr_ctrl.sv ====
module mbu_addr_ctrl (
   input  logic                   clk,
   input  logic                   arst_n,
   input  mbu_bus_pkg::cu_addr_t  waddr,
   input  mbu_reg_pkg::bank_idx_t ir,
   input  logic                   ir_idx,
   input  logic                   t34,
   input  mbu_bus_pkg::io_addr_t  ab,
   input  mbu_bus_pkg::byte_t     ibus_in,
   mbu_strobe_if.ctrl             strobes,
   mbu_rf_if.ctrl                 rf,
   output logic                   enabled
);

   // Latched request to index with ir[2:0] on the next AR write
   logic idx_flag;

   // Register selected by the low address bits of an I/O cycle
   mbu_reg_pkg::bank_idx_t ab_idx;

   assign ab_idx = mbu_reg_pkg::bank_idx_t'(ab);

   ////////////////////
   // Enable flag
   ////////////////////

   // The unit wakes up disabled and shows the front panel default
   // The first OUT to any of its registers turns it on for good
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         enabled <= 1'b0;
      end else if (strobes.io_wr) begin
         enabled <= 1'b1;
      end
   end

   // Auto-index latch
   // ir_idx wins over t34 when both are high at the same edge
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         idx_flag <= 1'b0;
      end else if (ir_idx) begin
         idx_flag <= 1'b1;
      end else if (t34) begin
         idx_flag <= 1'b0;
      end
   end

   ////////////////////
   // Write port
   ////////////////////

   // Both writers take their data from the internal bus
   // An OUT picks the register from ab, the microcode always hits MBP
   assign rf.we    = strobes.io_wr || strobes.write_mbp;
   assign rf.wa    = strobes.io_wr ? ab_idx : mbu_reg_pkg::reg_mbp;
   assign rf.wdata = ibus_in;

   ////////////////////
   // Read port
   ////////////////////

   // The read address also decides what aext shows in every cycle
   // read_mbp comes first, then indexed AR writes, then the I/O address
   always_comb begin
      rf.ra = ab_idx;
      if (strobes.read_mbp) begin
         rf.ra = mbu_reg_pkg::reg_mbp;
      end else if (strobes.war_sel) begin
         case (waddr[1:0])
            2'b00:   rf.ra = mbu_reg_pkg::reg_mbp;
            2'b01:   rf.ra = mbu_reg_pkg::reg_mbd;
            2'b10:   rf.ra = mbu_reg_pkg::reg_mbs;
            // Stack bank unless an auto-indexed instruction latched ir
            default: rf.ra = idx_flag ? ir : mbu_reg_pkg::reg_mbs;
         endcase
      end
   end

   // The two write sources share one port and both aim at MBP when ab is low
   // The control unit and the I/O bus must never write in the same cycle
   wr_conflict: assert property (
      @(posedge clk) disable iff (!arst_n)
      !(strobes.io_wr && strobes.write_mbp)
   ) else $error("write_mbp and an OUT to the unit in the same cycle");

endmodule

// ==== mbu_bus_drive.sv ====
`include "mbu_config.svh"

module mbu_bus_drive (
   input  logic               enabled,
   input  logic               fp_ram_n,
   input  mbu_bus_pkg::byte_t rdata,
   mbu_strobe_if.drive        strobes,
   output mbu_bus_pkg::byte_t aext,
   output mbu_bus_pkg::byte_t ibus_out,
   output logic [15:0]        db_out,
   output logic               ibus_oe,
   output logic               db_oe
);

   // Until the unit is enabled the extended address comes from the front panel
   // Bit 7 chooses RAM or ROM, the low bits read as zero
   assign aext = enabled ? rdata : {fp_ram_n, 7'b0};

   ////////////////////
   // Internal bus
   ////////////////////

   // read_mbp copies the current bank onto the internal bus
   assign ibus_out = aext;
   assign ibus_oe  = strobes.read_mbp;

   ////////////////////
   // Data bus
   ////////////////////

   // The register only fills the low byte of an IN
   // The upper byte imitates what bus hold would leave there
   assign db_out = {`MBU_DB_HOLD, aext};

   // only an IN inside the unit's window may drive the data bus
   assign db_oe = strobes.io_sel && strobes.io_rd;

endmodule

// ==== mbu_bus_pkg.sv ====
package mbu_bus_pkg;

   ////////////////////
   // Control unit side
   ////////////////////

   // Read and write addresses issued by the microcode
   // Both raddr and waddr use the same five bit encoding
   typedef logic [4:0] cu_addr_t;

   ////////////////////
   // Data paths
   ////////////////////

   // A byte on the internal bus or the low half of the data bus
   // Only the low eight bits of either bus reach the unit
   typedef logic [7:0] byte_t;

   // I/O address as seen on the low half of the address bus
   // The unit decodes all eight bits of it
   typedef logic [7:0] io_addr_t;

endpackage

// ==== mbu_config.svh ====
`ifndef MBU_CONFIG_SVH
`define MBU_CONFIG_SVH

// Number of bank registers held by the unit
`define MBU_NUM_REGS 8

// First I/O address of the unit, which occupies MBU_NUM_REGS addresses from here
`define MBU_IO_BASE 8'h08

// Byte returned on data bus bits 15 to 8 during an IN
// On the board this comes from bus hold after the last instruction fetch
`define MBU_DB_HOLD 8'h54

// Control unit read code for read_mbp
`define MBU_RADDR_RMBP 5'b01101

// Control unit write codes for write_mbp, compared on waddr[4:1]
`define MBU_WADDR_WMBP 4'b0110

// Control unit write codes for AR, compared on waddr[4:2]
`define MBU_WADDR_WAR 3'b001

`endif

// ==== mbu_decode.sv ====
`include "mbu_config.svh"

module mbu_decode (
   input  mbu_bus_pkg::cu_addr_t raddr,
   input  mbu_bus_pkg::cu_addr_t waddr,
   input  logic                  t34,
   input  logic                  sysdev,
   input  logic                  rd,
   input  logic                  wr,
   input  mbu_bus_pkg::io_addr_t ab,
   mbu_strobe_if.decoder         strobes
);

   // Window of I/O addresses owned by the unit
   localparam mbu_bus_pkg::io_addr_t io_base = `MBU_IO_BASE;
   localparam mbu_bus_pkg::io_addr_t io_last = io_base + 8'(`MBU_NUM_REGS - 1);

   logic in_window;

   ////////////////////
   // I/O space
   ////////////////////

   // The unit answers on one block of eight I/O addresses
   // On the board this was a '138 enabled by ab[3] with ab[7] low
   assign in_window = (ab >= io_base) && (ab <= io_last);

   // Only system device cycles reach I/O space, memory cycles never do
   assign strobes.io_sel = in_window && sysdev;

   // OUT and IN qualify the select with the bus direction
   assign strobes.io_wr = strobes.io_sel && wr;
   assign strobes.io_rd = strobes.io_sel && rd;

   ////////////////////
   // Control unit
   ////////////////////

   // read_mbp is suppressed in the t34 half of the cycle
   // The internal bus belongs to other sources then
   assign strobes.read_mbp = (raddr == `MBU_RADDR_RMBP) && !t34;

   // Two microcode writes land on MBP, so only the upper four bits matter
   assign strobes.write_mbp = (waddr[4:1] == `MBU_WADDR_WMBP);

   // Any write to AR indexes through the bank registers
   // waddr[1:0] then says which register supplies the bank
   assign strobes.war_sel = (waddr[4:2] == `MBU_WADDR_WAR);

   // The internal bus read and the data bus read would both need aext
   // at the same time, with two different read addresses
   // The deferred form waits for all inputs of the cycle to settle
   always_comb begin
      rd_conflict: assert final (!(strobes.read_mbp && strobes.io_rd))
         else $error("read_mbp and an IN to the unit in the same cycle");
   end

endmodule

// ==== mbu_ifs.sv ====
// Decoded strobes from the bus decoder
// Every signal is a level that holds for the whole cycle
interface mbu_strobe_if;
   logic io_sel;
   logic io_wr;
   logic io_rd;
   logic read_mbp;
   logic write_mbp;
   logic war_sel;

   // The decoder owns all six strobes
   modport decoder (
      output io_sel, io_wr, io_rd, read_mbp, write_mbp, war_sel
   );

   // Address control looks at the full set
   modport ctrl (
      input io_sel, io_wr, io_rd, read_mbp, write_mbp, war_sel
   );

   // Output drivers only care about the read side
   modport drive (
      input io_sel, io_rd, read_mbp
   );
endinterface

// One write port and one read port into the bank registers
interface mbu_rf_if;
   logic                    we;
   mbu_reg_pkg::bank_idx_t  wa;
   mbu_bus_pkg::byte_t      wdata;
   mbu_reg_pkg::bank_idx_t  ra;
   mbu_bus_pkg::byte_t      rdata;

   modport ctrl (output we, wa, wdata, ra, input rdata);

   modport rf (input we, wa, wdata, ra, output rdata);
endinterface

// ==== mbu_reg_pkg.sv ====
`include "mbu_config.svh"

package mbu_reg_pkg;

   // Index of one bank register
   // The width follows the register count in the config header
   typedef logic [$clog2(`MBU_NUM_REGS)-1:0] bank_idx_t;

   ////////////////////
   // Named registers
   ////////////////////

   // Memory bank for program fetches
   // Also the only register the control unit can write directly
   localparam bank_idx_t reg_mbp = bank_idx_t'(0);

   // Memory bank for data accesses
   localparam bank_idx_t reg_mbd = bank_idx_t'(1);

   // Memory bank for the stack
   // Also the fallback for indexed AR writes without auto-indexing
   localparam bank_idx_t reg_mbs = bank_idx_t'(2);

endpackage

// ==== mbu_regfile.sv ====
`include "mbu_config.svh"

module mbu_regfile (
   input  logic  clk,
   input  logic  arst_n,
   mbu_rf_if.rf  rf
);

   // The bank registers themselves
   // On the board these were four '670 register file chips
   mbu_bus_pkg::byte_t regs [`MBU_NUM_REGS];

   ////////////////////
   // Write port
   ////////////////////

   // Every register starts at zero so the first banks are well defined
   // Writes land at the edge and show up from the next cycle on
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `MBU_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (rf.we) begin
         regs[rf.wa] <= rf.wdata;
      end
   end

   ////////////////////
   // Read port
   ////////////////////

   // Asynchronous read
   // aext has to follow the read address within the same cycle
   assign rf.rdata = regs[rf.ra];

   // The write address comes from ab during an OUT
   // An undriven address bus would silently corrupt some register
   wa_known: assert property (
      @(posedge clk) disable iff (!arst_n)
      rf.we |-> !$isunknown(rf.wa)
   ) else $error("bank register write with an unknown address");

endmodule

// ==== mbu_top.f ====
+incdir+.
mbu_bus_pkg.sv
mbu_reg_pkg.sv
mbu_ifs.sv
mbu_decode.sv
mbu_addr_ctrl.sv
mbu_regfile.sv
mbu_bus_drive.sv
mbu_top.sv
tb_mbu_top.sv

// ==== mbu_top.sv ====
module mbu_top (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [4:0]  raddr,
   input  logic [4:0]  waddr,
   input  logic [2:0]  ir,
   input  logic        ir_idx,
   input  logic        t34,
   input  logic        sysdev,
   input  logic        rd,
   input  logic        wr,
   input  logic        fp_ram_n,
   input  logic [7:0]  ab,
   input  logic [7:0]  ibus_in,
   output logic [7:0]  aext,
   output logic [7:0]  ibus_out,
   output logic        ibus_oe,
   output logic        db_oe,
   output logic        war,
   output logic [15:0] db_out
);

   // Decoded strobes shared by the control and output blocks
   mbu_strobe_if strobe_bus ();

   // Path between address control and the bank registers
   mbu_rf_if rf_bus ();

   // Set by the first OUT, cleared only by reset
   logic enabled;

   ////////////////////
   // Decode
   ////////////////////

   mbu_decode u_decode (
      .raddr   (raddr),
      .waddr   (waddr),
      .t34     (t34),
      .sysdev  (sysdev),
      .rd      (rd),
      .wr      (wr),
      .ab      (ab),
      .strobes (strobe_bus.decoder)
   );

   // The AR write decode is handy to the address register as well
   assign war = strobe_bus.war_sel;

   ////////////////////
   // Registers
   ////////////////////

   mbu_addr_ctrl u_addr_ctrl (
      .clk     (clk),
      .arst_n  (arst_n),
      .waddr   (waddr),
      .ir      (ir),
      .ir_idx  (ir_idx),
      .t34     (t34),
      .ab      (ab),
      .ibus_in (ibus_in),
      .strobes (strobe_bus.ctrl),
      .rf      (rf_bus.ctrl),
      .enabled (enabled)
   );

   mbu_regfile u_regfile (
      .clk    (clk),
      .arst_n (arst_n),
      .rf     (rf_bus.rf)
   );

   // Output side, all combinational from the selected register
   mbu_bus_drive u_bus_drive (
      .enabled  (enabled),
      .fp_ram_n (fp_ram_n),
      .rdata    (rf_bus.rdata),
      .strobes  (strobe_bus.drive),
      .aext     (aext),
      .ibus_out (ibus_out),
      .db_out   (db_out),
      .ibus_oe  (ibus_oe),
      .db_oe    (db_oe)
   );

endmodule

// ==== mbu_vectors.txt ====
// One line per cycle after reset, all fields hex. Inputs first, then expected outputs:
// test raddr waddr ir ir_idx t34 sysdev rd wr fp_ram_n ab ibus_in aext ibus_oe ibus_out db_oe db_out war
1 00 00 0 0 0 0 0 0 0 00 00  00 0 00 0 5400 0
1 00 00 0 0 0 0 0 0 1 00 00  80 0 80 0 5480 0
1 00 0D 0 0 0 0 0 0 1 00 A5  80 0 80 0 5480 0
1 0D 00 0 0 0 0 0 0 1 00 00  80 1 80 0 5480 0
2 00 00 0 0 0 1 0 1 1 08 10  80 0 80 0 5480 0
2 00 00 0 0 0 1 0 1 1 09 21  00 0 00 0 5400 0
2 00 00 0 0 0 1 0 1 1 0A 32  00 0 00 0 5400 0
2 00 00 0 0 0 1 0 1 1 0B 43  00 0 00 0 5400 0
2 00 00 0 0 0 1 0 1 1 0C 5A  00 0 00 0 5400 0
2 00 00 0 0 0 1 0 1 1 0D 6B  00 0 00 0 5400 0
2 00 00 0 0 0 1 0 1 1 0E 7C  00 0 00 0 5400 0
2 00 00 0 0 0 1 0 1 1 0F 8D  00 0 00 0 5400 0
2 00 00 0 0 0 1 1 0 1 08 00  10 0 10 1 5410 0
2 00 00 0 0 0 1 1 0 1 0B 00  43 0 43 1 5443 0
2 00 00 0 0 0 1 1 0 1 0F 00  8D 0 8D 1 548D 0
2 00 00 0 0 0 1 1 0 1 0C 00  5A 0 5A 1 545A 0
2 00 00 0 0 0 1 1 0 1 09 00  21 0 21 1 5421 0
2 00 00 0 0 0 1 1 0 1 0A 00  32 0 32 1 5432 0
2 00 00 0 0 0 1 1 0 1 0D 00  6B 0 6B 1 546B 0
2 00 00 0 0 0 1 1 0 1 0E 00  7C 0 7C 1 547C 0
3 00 0C 0 0 0 0 0 0 1 00 C3  10 0 10 0 5410 0
3 0D 00 0 0 0 0 0 0 1 00 00  C3 1 C3 0 54C3 0
3 0D 0D 0 0 0 0 0 0 1 00 9E  C3 1 C3 0 54C3 0
3 0D 00 0 0 0 0 0 0 1 00 00  9E 1 9E 0 549E 0
4 00 04 0 0 0 0 0 0 1 00 00  9E 0 9E 0 549E 1
4 00 05 0 0 0 0 0 0 1 00 00  21 0 21 0 5421 1
4 00 06 0 0 0 0 0 0 1 00 00  32 0 32 0 5432 1
4 00 07 5 0 0 0 0 0 1 00 00  32 0 32 0 5432 1
4 00 00 5 1 0 0 0 0 1 00 00  9E 0 9E 0 549E 0
4 00 07 5 0 0 0 0 0 1 00 00  6B 0 6B 0 546B 1
4 00 07 3 0 0 0 0 0 1 00 00  43 0 43 0 5443 1
4 00 00 3 0 1 0 0 0 1 00 00  9E 0 9E 0 549E 0
4 00 07 3 0 0 0 0 0 1 00 00  32 0 32 0 5432 1
5 00 00 0 0 0 1 0 1 1 07 FF  8D 0 8D 0 548D 0
5 00 00 0 0 0 1 0 1 1 10 EE  9E 0 9E 0 549E 0
5 00 00 0 0 0 0 0 1 1 08 DD  9E 0 9E 0 549E 0
5 00 00 0 0 0 1 1 0 1 07 00  8D 0 8D 0 548D 0
5 00 00 0 0 0 1 1 0 1 10 00  9E 0 9E 0 549E 0
5 00 00 0 0 0 0 1 0 1 08 00  9E 0 9E 0 549E 0
5 0D 00 0 0 1 0 0 0 1 0F 00  8D 0 8D 0 548D 0
5 00 00 0 0 0 1 1 0 1 08 00  9E 0 9E 1 549E 0

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the MBU testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f mbu_top.f \
   --top-module tb_mbu_top -o sim_mbu > build.log 2>&1 \
   && ./obj_dir/sim_mbu > sim.log 2>&1 \
   || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -qx "NO ERRORS" sim.log \
   && echo "PASS" \
   || { echo "FAIL, see sim.log"; exit 1; }

// ==== tb_mbu_top.sv ====
module tb_mbu_top;
   timeunit 1ns;
   timeprecision 1ps;

   // Vector file layout, one row per cycle with inputs then expected outputs
   localparam int num_vecs     = 41;
   localparam int num_cols     = 18;
   localparam int reset_cycles = 8;
   localparam int cycle_limit  = reset_cycles + num_vecs + 20;

   logic        clk;
   logic        arst_n;
   logic [4:0]  raddr;
   logic [4:0]  waddr;
   logic [2:0]  ir;
   logic        ir_idx;
   logic        t34;
   logic        sysdev;
   logic        rd;
   logic        wr;
   logic        fp_ram_n;
   logic [7:0]  ab;
   logic [7:0]  ibus_in;
   logic [7:0]  aext;
   logic [7:0]  ibus_out;
   logic        ibus_oe;
   logic        db_oe;
   logic        war;
   logic [15:0] db_out;

   logic [15:0] vec_mem [num_vecs * num_cols];
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   bit          loaded;

   mbu_top dut (
      .clk(clk), .arst_n(arst_n), .raddr(raddr), .waddr(waddr), .ir(ir),
      .ir_idx(ir_idx), .t34(t34), .sysdev(sysdev), .rd(rd), .wr(wr),
      .fp_ram_n(fp_ram_n), .ab(ab), .ibus_in(ibus_in), .aext(aext),
      .ibus_out(ibus_out), .ibus_oe(ibus_oe), .db_oe(db_oe), .war(war),
      .db_out(db_out)
   );

   // 20 ns clock
   always #10 clk = ~clk;

   // Run limit, a few cycles of slack past reset plus every vector
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout: the run did not end within %0d cycles", cycle_limit);
         $display("Checks run: %0d, errors: %0d", checks, errors + 1);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   ////////////////////
   // Vector access
   ////////////////////

   function automatic logic [15:0] vec_field(input int row, input int col);
      return vec_mem[row * num_cols + col];
   endfunction

   // Column 0 numbers the behavior that a row exercises
   function automatic string test_name(input logic [15:0] id);
      case (id)
         16'd1:   return "power_on_default";
         16'd2:   return "io_fill_and_read";
         16'd3:   return "microcode_mbp";
         16'd4:   return "ar_indexing";
         16'd5:   return "decode_bounds";
         default: return "unknown";
      endcase
   endfunction

   // A row left at zero means the file ended early
   function automatic bit file_complete();
      for (int row = 0; row < num_vecs; row++) begin
         if (vec_field(row, 0) == 16'd0) begin
            $display("Vector file mbu_vectors.txt has no valid row %0d", row);
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   ////////////////////
   // Drive and check
   ////////////////////

   task automatic compare_value(input string test, input string sig,
                                input logic [15:0] expected, input logic [15:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH %s %s expected %h actual %h", test, sig, expected, actual);
      end
   endtask

   // Called right after a rising edge so the DUT sees the new row next cycle
   task automatic apply_vector(input int row);
      raddr    <= 5'(vec_field(row, 1));
      waddr    <= 5'(vec_field(row, 2));
      ir       <= 3'(vec_field(row, 3));
      ir_idx   <= 1'(vec_field(row, 4));
      t34      <= 1'(vec_field(row, 5));
      sysdev   <= 1'(vec_field(row, 6));
      rd       <= 1'(vec_field(row, 7));
      wr       <= 1'(vec_field(row, 8));
      fp_ram_n <= 1'(vec_field(row, 9));
      ab       <= 8'(vec_field(row, 10));
      ibus_in  <= 8'(vec_field(row, 11));
   endtask

   // Outputs are combinational, so mid-cycle they have long settled
   task automatic check_vector(input int row);
      string name;
      name = $sformatf("%s[%0d]", test_name(vec_field(row, 0)), row);
      compare_value(name, "aext", vec_field(row, 12), 16'(aext));
      compare_value(name, "ibus_oe", vec_field(row, 13), 16'(ibus_oe));
      compare_value(name, "ibus_out", vec_field(row, 14), 16'(ibus_out));
      compare_value(name, "db_oe", vec_field(row, 15), 16'(db_oe));
      compare_value(name, "db_out", vec_field(row, 16), db_out);
      compare_value(name, "war", vec_field(row, 17), 16'(war));
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      clk      = 1'b0;
      arst_n   = 1'b0;
      raddr    = '0;
      waddr    = '0;
      ir       = '0;
      ir_idx   = 1'b0;
      t34      = 1'b0;
      sysdev   = 1'b0;
      rd       = 1'b0;
      wr       = 1'b0;
      fp_ram_n = 1'b0;
      ab       = '0;
      ibus_in  = '0;
      for (int i = 0; i < num_vecs * num_cols; i++) begin
         vec_mem[i] = '0;
      end
      $readmemh("mbu_vectors.txt", vec_mem);
      loaded = file_complete();

      repeat (reset_cycles) @(posedge clk);
      arst_n <= 1'b1;

      if (loaded) begin
         for (int row = 0; row < num_vecs; row++) begin
            @(posedge clk);
            apply_vector(row);
            @(negedge clk);
            check_vector(row);
         end
      end else begin
         errors++;
      end

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
